//--- logic/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

  // ====================
  // FIFO dimensions
  // ====================

  // Number of request entries held in flip-flops
  localparam int FIFO_DEPTH = 7;

  // Pointer and address width covers depths up to 8
  localparam int ADDR_W = 3;

  // Occupancy counts must reach FIFO_DEPTH itself, so one bit more than the pointers
  localparam int COUNT_W = 4;

  // Width of one host request word
  localparam int DATA_W = 39;

  // Sized forms of the constants above for the pointer and count logic
  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(FIFO_DEPTH - 1);
  localparam logic [ADDR_W-1:0] ADDR_ONE = ADDR_W'(1);
  localparam logic [COUNT_W-1:0] DEPTH_COUNT = COUNT_W'(FIFO_DEPTH);
  localparam logic [COUNT_W-1:0] COUNT_ONE = COUNT_W'(1);

  // ====================
  // Operating mode
  // ====================

  // Encodings match the two-bit mode field of the host interface
  typedef enum logic [1:0] {
    MODE_FLAG_WITH_DATA   = 2'd0,
    MODE_DATA_BEFORE_FLAG = 2'd1,
    MODE_FLAG_BEFORE_DATA = 2'd2
  } fifo_mode_e;

endpackage

`default_nettype wire

//--- logic/fifo_flag_control.sv
`default_nettype none

module fifo_flag_control (
  input  wire                          write_clk,
  input  wire                          rst_n,
  input  fifo_pkg::fifo_mode_e         fifo_mode,
  input  wire                          write_submit,
  input  wire                          read_remove,
  output logic                         room_available,
  output logic                         data_available,
  output logic                         write_error,
  output logic                         read_error,
  output logic                         write_capture,
  output logic                         read_enable,
  output logic [fifo_pkg::ADDR_W-1:0]  write_address,
  output logic [fifo_pkg::ADDR_W-1:0]  read_address
);

  // Pointers into the storage array wrap at FIFO_DEPTH
  logic [fifo_pkg::ADDR_W-1:0]  write_ptr;
  logic [fifo_pkg::ADDR_W-1:0]  read_ptr;

  // Reserved count covers every accepted word not yet removed
  logic [fifo_pkg::COUNT_W-1:0] reserved_count;

  // Published count covers only words the reader is allowed to see
  logic [fifo_pkg::COUNT_W-1:0] published_count;

  // Holds a write for one edge before it is published
  logic                         pending_publish;

  logic                         delay_publish;
  logic                         write_accept;
  logic                         read_accept;
  logic                         publish_inc;

  // ====================
  // Flags and strobes
  // ====================

  // Only the data-before-flag mode holds back the published count
  assign delay_publish = (fifo_mode == fifo_pkg::MODE_DATA_BEFORE_FLAG);

  assign room_available = (reserved_count < fifo_pkg::DEPTH_COUNT);
  assign data_available = (published_count != '0);

  // The read side of the storage is live whenever something is published
  assign read_enable = data_available;

  // A submit or remove against a closed flag is dropped here
  assign write_accept = write_submit & room_available;
  assign read_accept = read_remove & data_available;

  // Storage only captures words that were actually accepted
  assign write_capture = write_accept;
  assign write_address = write_ptr;
  assign read_address = read_ptr;

  // Published increment comes either with the write or one edge after it
  assign publish_inc = delay_publish ? pending_publish : write_accept;

  // Error strobes are single-cycle pulses after the offending edge
  always_ff @(posedge write_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      write_error <= 1'b0;
      read_error <= 1'b0;
    end
    else
    begin
      write_error <= write_submit & ~room_available;
      read_error <= read_remove & ~data_available;
    end
  end

  // ====================
  // Pointers
  // ====================

  always_ff @(posedge write_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      write_ptr <= '0;
      read_ptr <= '0;
    end
    else
    begin
      if (write_accept)
      begin
        write_ptr <= (write_ptr == fifo_pkg::LAST_ADDR) ? '0 : write_ptr + fifo_pkg::ADDR_ONE;
      end
      if (read_accept)
      begin
        read_ptr <= (read_ptr == fifo_pkg::LAST_ADDR) ? '0 : read_ptr + fifo_pkg::ADDR_ONE;
      end
    end
  end

  // ====================
  // Occupancy counts
  // ====================

  always_ff @(posedge write_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      reserved_count <= '0;
      published_count <= '0;
      pending_publish <= 1'b0;
    end
    else
    begin
      // Outside the delayed mode this stays clear
      pending_publish <= write_accept & delay_publish;

      // Simultaneous submit and remove leave the reserved count alone
      if (write_accept && !read_accept)
      begin
        reserved_count <= reserved_count + fifo_pkg::COUNT_ONE;
      end
      else if (!write_accept && read_accept)
      begin
        reserved_count <= reserved_count - fifo_pkg::COUNT_ONE;
      end

      // A remove never outruns publication since it needs data_available
      if (publish_inc && !read_accept)
      begin
        published_count <= published_count + fifo_pkg::COUNT_ONE;
      end
      else if (!publish_inc && read_accept)
      begin
        published_count <= published_count - fifo_pkg::COUNT_ONE;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/fifo_storage.sv
`default_nettype none

module fifo_storage (
  input  wire                          write_clk,
  input  wire                          write_capture,
  input  wire  [fifo_pkg::ADDR_W-1:0]  write_address,
  input  wire  [fifo_pkg::DATA_W-1:0]  write_data,
  input  wire  [fifo_pkg::ADDR_W-1:0]  read_address,
  output logic [fifo_pkg::DATA_W-1:0]  head_data
);

  // One flip-flop word per FIFO entry
  logic [fifo_pkg::DATA_W-1:0] storage [fifo_pkg::FIFO_DEPTH];

  // ====================
  // Write side
  // ====================

  // Each entry has its own enable decoded from the write address
  // The control block only raises write_capture for accepted words
  for (genvar i = 0; i < fifo_pkg::FIFO_DEPTH; i++)
  begin : g_entry
    logic entry_write;

    assign entry_write = write_capture && (int'(write_address) == i);

    always_ff @(posedge write_clk)
    begin
      if (entry_write)
      begin
        storage[i] <= write_data;
      end
    end
  end

  // ====================
  // Read side
  // ====================

  // Plain multiplexer on the read pointer with no read clock involved
  // Addresses beyond the last entry never occur and return zero
  always_comb
  begin
    head_data = '0;
    for (int j = 0; j < fifo_pkg::FIFO_DEPTH; j++)
    begin
      if (int'(read_address) == j)
      begin
        head_data = storage[j];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/read_data_stage.sv
`default_nettype none

module read_data_stage (
  input  wire                          write_clk,
  input  wire                          rst_n,
  input  fifo_pkg::fifo_mode_e         fifo_mode,
  input  wire                          read_enable,
  input  wire  [fifo_pkg::DATA_W-1:0]  head_data,
  output logic [fifo_pkg::DATA_W-1:0]  read_data
);

  // Registered copy of the head entry for the flag-before-data mode
  logic [fifo_pkg::DATA_W-1:0] data_reg;
  logic                        flag_before_data;

  assign flag_before_data = (fifo_mode == fifo_pkg::MODE_FLAG_BEFORE_DATA);

  // The register follows the head one clock behind while data is published
  // so the reader has to wait one clock after the flag and after each remove
  always_ff @(posedge write_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_reg <= '0;
    end
    else if (flag_before_data && read_enable)
    begin
      data_reg <= head_data;
    end
  end

  // Other modes see the storage multiplexer directly
  assign read_data = flag_before_data ? data_reg : head_data;

endmodule

`default_nettype wire

//--- logic/host_request_fifo.sv
`default_nettype none

module host_request_fifo (
  input  wire                          write_clk,
  input  wire                          rst_n,
  input  fifo_pkg::fifo_mode_e         fifo_mode,
  input  wire                          write_submit,
  input  wire  [fifo_pkg::DATA_W-1:0]  write_data,
  input  wire                          read_remove,
  output logic                         room_available,
  output logic                         data_available,
  output logic [fifo_pkg::DATA_W-1:0]  read_data,
  output logic                         write_error,
  output logic                         read_error
);

  // ====================
  // Internal wiring
  // ====================

  // Storage write strobe and addresses come from the flag logic
  logic                          write_capture;
  logic                          read_enable;
  logic [fifo_pkg::ADDR_W-1:0]   write_address;
  logic [fifo_pkg::ADDR_W-1:0]   read_address;

  // Word at the current read pointer
  logic [fifo_pkg::DATA_W-1:0]   head_data;

  // Pointers, counts, flags and error strobes
  fifo_flag_control u_flag_control (
    .write_clk      (write_clk),
    .rst_n          (rst_n),
    .fifo_mode      (fifo_mode),
    .write_submit   (write_submit),
    .read_remove    (read_remove),
    .room_available (room_available),
    .data_available (data_available),
    .write_error    (write_error),
    .read_error     (read_error),
    .write_capture  (write_capture),
    .read_enable    (read_enable),
    .write_address  (write_address),
    .read_address   (read_address)
  );

  // Flip-flop array holding the queued requests
  fifo_storage u_storage (
    .write_clk     (write_clk),
    .write_capture (write_capture),
    .write_address (write_address),
    .write_data    (write_data),
    .read_address  (read_address),
    .head_data     (head_data)
  );

  // Mode dependent output path
  read_data_stage u_read_stage (
    .write_clk   (write_clk),
    .rst_n       (rst_n),
    .fifo_mode   (fifo_mode),
    .read_enable (read_enable),
    .head_data   (head_data),
    .read_data   (read_data)
  );

endmodule

`default_nettype wire

//--- tb/host_request_fifo_props.sv
`default_nettype none

module host_request_fifo_props (
  input wire write_clk,
  input wire rst_n,
  input wire room_available,
  input wire data_available,
  input wire write_error,
  input wire read_error
);

  // While reset is held the FIFO looks empty and no error is flagged
  reset_flags_a: assert property (@(posedge write_clk)
    !rst_n |-> (room_available && !data_available && !write_error && !read_error))
    else $error("Flags differ from their reset values while rst_n is low");

  // Error strobes are single-cycle pulses
  write_error_pulse_a: assert property (@(posedge write_clk) disable iff (!rst_n)
    write_error |=> !write_error)
    else $error("write_error stayed high for more than one cycle");

  read_error_pulse_a: assert property (@(posedge write_clk) disable iff (!rst_n)
    read_error |=> !read_error)
    else $error("read_error stayed high for more than one cycle");

  // With two or more entries the FIFO cannot be full and empty at once
  flags_not_both_low_a: assert property (@(posedge write_clk) disable iff (!rst_n)
    room_available || data_available)
    else $error("room_available and data_available are both low");

endmodule

`default_nettype wire

//--- tb/host_request_fifo_tb.sv
`default_nettype none

module host_request_fifo_tb;

  localparam int CLK_PERIOD = 100;
  localparam int STREAM_CYCLES = 300;
  localparam int WAIT_LIMIT = 20;
  // Cycle estimate for seven resets, directed tests and three streams
  localparam int TEST_CYCLES = 7 * 6 + 100 + 3 * (STREAM_CYCLES + 2 * fifo_pkg::FIFO_DEPTH);
  localparam int WATCHDOG_TIME = (2 * TEST_CYCLES + 200) * CLK_PERIOD;

  logic                         write_clk = 1'b0;
  logic                         rst_n;
  fifo_pkg::fifo_mode_e         fifo_mode;
  logic                         write_submit;
  logic [fifo_pkg::DATA_W-1:0]  write_data;
  logic                         read_remove;
  wire                          room_available;
  wire                          data_available;
  wire  [fifo_pkg::DATA_W-1:0]  read_data;
  wire                          write_error;
  wire                          read_error;

  logic [31:0]                  lfsr_state = 32'h059f37b5;
  // Words accepted by the DUT and not yet removed with the oldest at the front
  logic [fifo_pkg::DATA_W-1:0]  ref_queue [$];

  host_request_fifo UUT (
    .write_clk      (write_clk),
    .rst_n          (rst_n),
    .fifo_mode      (fifo_mode),
    .write_submit   (write_submit),
    .write_data     (write_data),
    .read_remove    (read_remove),
    .room_available (room_available),
    .data_available (data_available),
    .read_data      (read_data),
    .write_error    (write_error),
    .read_error     (read_error)
  );

  bind host_request_fifo host_request_fifo_props u_props (
    .write_clk      (write_clk),
    .rst_n          (rst_n),
    .room_available (room_available),
    .data_available (data_available),
    .write_error    (write_error),
    .read_error     (read_error)
  );

  always #(CLK_PERIOD / 2) write_clk = ~write_clk;

  initial
  begin
    #(WATCHDOG_TIME);
    $display("ERROR: watchdog expired before the tests finished");
    $display("Test failed");
    $fatal(1);
  end

  // ====================
  // Helpers
  // ====================

  // Galois LFSR with taps 32, 31, 29 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    lfsr_next = state[0] ? ((state >> 1) ^ 32'hD0000001) : (state >> 1);
  endfunction

  // One LFSR step per bit taken and bits fill from the LSB up
  task automatic take_bits(input int count, output logic [63:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++)
    begin
      bits[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic random_word(output logic [fifo_pkg::DATA_W-1:0] word);
    logic [63:0] bits;
    take_bits(fifo_pkg::DATA_W, bits);
    word = bits[fifo_pkg::DATA_W-1:0];
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("FAIL time=%0t signal=%s actual=%0h expected=%0h", $time, name, actual, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // Mode is changed only while reset is held
  task automatic apply_reset(input fifo_pkg::fifo_mode_e mode);
    rst_n = 1'b0;
    fifo_mode = mode;
    write_submit = 1'b0;
    read_remove = 1'b0;
    ref_queue.delete();
    repeat (5) @(negedge write_clk);
    rst_n = 1'b1;
    @(negedge write_clk);
    check_value("room_available", 64'(room_available), 64'd1);
    check_value("data_available", 64'(data_available), 64'd0);
    check_value("write_error", 64'(write_error), 64'd0);
    check_value("read_error", 64'(read_error), 64'd0);
    if (mode == fifo_pkg::MODE_FLAG_BEFORE_DATA)
      check_value("read_data", 64'(read_data), 64'd0);
  endtask

  // Submits random words back to back and expects room before each one
  task automatic fill_words(input int count);
    logic [fifo_pkg::DATA_W-1:0] word;
    repeat (count)
    begin
      check_value("room_available", 64'(room_available), 64'd1);
      random_word(word);
      write_submit = 1'b1;
      write_data = word;
      @(negedge write_clk);
      write_submit = 1'b0;
      ref_queue.push_back(word);
    end
  endtask

  // Waits for the flag, applies the one-clock wait of flag-before-data mode,
  // checks the head word and pops it
  task automatic remove_checked();
    int waited;
    waited = 0;
    while (!data_available && waited < WAIT_LIMIT)
    begin
      @(negedge write_clk);
      waited++;
    end
    if (!data_available)
    begin
      $display("ERROR: data_available did not rise within %0d cycles", WAIT_LIMIT);
      $display("Test failed");
      $fatal(1);
    end
    if (fifo_mode == fifo_pkg::MODE_FLAG_BEFORE_DATA)
      @(negedge write_clk);
    check_value("read_data", 64'(read_data), 64'(ref_queue[0]));
    read_remove = 1'b1;
    @(negedge write_clk);
    read_remove = 1'b0;
    void'(ref_queue.pop_front());
  endtask

  task automatic drain_queue();
    while (ref_queue.size() > 0)
      remove_checked();
    check_value("data_available", 64'(data_available), 64'd0);
    check_value("room_available", 64'(room_available), 64'd1);
  endtask

  // ====================
  // Tests
  // ====================

  task automatic fill_drain_test();
    apply_reset(fifo_pkg::MODE_FLAG_WITH_DATA);
    fill_words(fifo_pkg::FIFO_DEPTH);
    check_value("room_available", 64'(room_available), 64'd0);
    check_value("data_available", 64'(data_available), 64'd1);
    drain_queue();
  endtask

  task automatic overflow_underflow_test();
    logic [fifo_pkg::DATA_W-1:0] word;
    apply_reset(fifo_pkg::MODE_FLAG_WITH_DATA);
    fill_words(fifo_pkg::FIFO_DEPTH);
    // This word is dropped and never enters the reference queue
    random_word(word);
    write_submit = 1'b1;
    write_data = word;
    @(negedge write_clk);
    write_submit = 1'b0;
    check_value("write_error", 64'(write_error), 64'd1);
    @(negedge write_clk);
    check_value("write_error", 64'(write_error), 64'd0);
    drain_queue();
    read_remove = 1'b1;
    @(negedge write_clk);
    read_remove = 1'b0;
    check_value("read_error", 64'(read_error), 64'd1);
    @(negedge write_clk);
    check_value("read_error", 64'(read_error), 64'd0);
    check_value("data_available", 64'(data_available), 64'd0);
  endtask

  task automatic data_before_flag_test();
    apply_reset(fifo_pkg::MODE_DATA_BEFORE_FLAG);
    fill_words(1);
    // Flag lags the write by one edge
    check_value("data_available", 64'(data_available), 64'd0);
    @(negedge write_clk);
    check_value("data_available", 64'(data_available), 64'd1);
    fill_words(fifo_pkg::FIFO_DEPTH - 1);
    // Room drops at the edge of the last write
    check_value("room_available", 64'(room_available), 64'd0);
    drain_queue();
  endtask

  task automatic flag_before_data_test();
    apply_reset(fifo_pkg::MODE_FLAG_BEFORE_DATA);
    fill_words(1);
    // Flag is up but the output register still holds its reset value
    check_value("data_available", 64'(data_available), 64'd1);
    check_value("read_data", 64'(read_data), 64'd0);
    // One clock later the register has caught the head entry
    @(negedge write_clk);
    check_value("read_data", 64'(read_data), 64'(ref_queue[0]));
    fill_words(2);
    drain_queue();
  endtask

  task automatic stream_test(input fifo_pkg::fifo_mode_e mode);
    logic [63:0] bits;
    logic [fifo_pkg::DATA_W-1:0] word;
    logic do_submit;
    logic do_remove;
    logic prev_data;
    logic prev_removed;
    apply_reset(mode);
    prev_data = 1'b0;
    prev_removed = 1'b0;
    repeat (STREAM_CYCLES)
    begin
      check_value("room_available", 64'(room_available),
                  64'(ref_queue.size() < fifo_pkg::FIFO_DEPTH));
      // The delayed flag may lag the queue except when nothing is stored
      if (mode != fifo_pkg::MODE_DATA_BEFORE_FLAG || ref_queue.size() == 0)
        check_value("data_available", 64'(data_available), 64'(ref_queue.size() != 0));
      take_bits(1, bits);
      do_submit = bits[0] && room_available;
      take_bits(1, bits);
      // Registered output is valid once the flag was up and no remove hit the last edge
      do_remove = bits[0] && data_available &&
                  (mode != fifo_pkg::MODE_FLAG_BEFORE_DATA || (prev_data && !prev_removed));
      if (do_remove)
        check_value("read_data", 64'(read_data), 64'(ref_queue[0]));
      word = write_data;
      if (do_submit)
        random_word(word);
      write_data = word;
      write_submit = do_submit;
      read_remove = do_remove;
      prev_data = data_available;
      @(negedge write_clk);
      write_submit = 1'b0;
      read_remove = 1'b0;
      if (do_remove)
        void'(ref_queue.pop_front());
      if (do_submit)
        ref_queue.push_back(word);
      prev_removed = do_remove;
    end
    drain_queue();
  endtask

  initial
  begin
    rst_n = 1'b0;
    fifo_mode = fifo_pkg::MODE_FLAG_WITH_DATA;
    write_submit = 1'b0;
    write_data = '0;
    read_remove = 1'b0;
    fill_drain_test();
    overflow_underflow_test();
    data_before_flag_test();
    flag_before_data_test();
    stream_test(fifo_pkg::MODE_FLAG_WITH_DATA);
    stream_test(fifo_pkg::MODE_DATA_BEFORE_FLAG);
    stream_test(fifo_pkg::MODE_FLAG_BEFORE_DATA);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- host_request_fifo.f
logic/fifo_pkg.sv
logic/fifo_flag_control.sv
logic/fifo_storage.sv
logic/read_data_stage.sv
logic/host_request_fifo.sv
tb/host_request_fifo_props.sv
tb/host_request_fifo_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for a failure

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f host_request_fifo.f \
  --top-module host_request_fifo_tb -o host_request_fifo_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile step returned an error"
  exit 1
fi

./obj_dir/host_request_fifo_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0
